/* logic/soc_pkg.sv */
package soc_pkg;

  // ####################
  // bus widths
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;
  localparam int ADR_W  = 32;

  // ####################
  // address map
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;
  localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

  localparam logic [REGION_W-1:0] REGION_RAM = 4'h0;
  localparam logic [REGION_W-1:0] REGION_CSR = 4'h2;
  localparam logic [REGION_W-1:0] REGION_SPI = 4'h3;

  // on-chip ram, in words
  localparam int RAM_DEPTH = 256;
  localparam int RAM_AW    = $clog2(RAM_DEPTH);

  // csr word offsets
  localparam logic [RAM_AW-1:0] CSR_GPI      = 8'd0;
  localparam logic [RAM_AW-1:0] CSR_GPO      = 8'd1;
  localparam logic [RAM_AW-1:0] CSR_GPOE     = 8'd2;
  localparam logic [RAM_AW-1:0] CSR_SPI_CONF = 8'd3;
  localparam logic [RAM_AW-1:0] CSR_STATUS   = 8'd4;

  // spi data register inside its region
  localparam logic [RAM_AW-1:0] SPI_DATA = 8'd0;

  // ####################
  // peripherals
  localparam int GPIO_W  = 8;
  localparam int PRESC_W = 4;

  localparam logic [1:0] SPI_SIZE_8  = 2'd0;
  localparam logic [1:0] SPI_SIZE_16 = 2'd1;
  localparam logic [1:0] SPI_SIZE_32 = 2'd2;

  // spi_conf layout, prescaler sits in the low bits
  localparam int CONF_CPOL_BIT = 4;
  localparam int CONF_SIZE_LSB = 5;

  // enough to hold a full word of bits
  localparam int BCNT_W = $clog2(DATA_W) + 1;

  // core reset release, in cycles
  localparam int RST_DELAY = 16;

endpackage

/* logic/bus_ctrl.sv */
`timescale 1ns/1ps

module bus_ctrl import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_in,
  // instruction port
  input  logic              imem_stb_i,
  input  logic [ADR_W-1:0]  imem_adr_i,
  output logic [DATA_W-1:0] imem_rdat_o,
  output logic              imem_ack_o,
  // data port
  input  logic              dmem_stb_i,
  input  logic              dmem_we_i,
  input  logic [BE_W-1:0]   dmem_be_i,
  input  logic [ADR_W-1:0]  dmem_adr_i,
  input  logic [DATA_W-1:0] dmem_wdat_i,
  output logic [DATA_W-1:0] dmem_rdat_o,
  output logic              dmem_ack_o,
  // slave side
  output logic              ram_stb_o,
  output logic              csr_stb_o,
  output logic              spi_stb_o,
  output logic              we_o,
  output logic [BE_W-1:0]   be_o,
  output logic [RAM_AW-1:0] wadr_o,
  output logic [DATA_W-1:0] wdat_o,
  input  logic              ram_ack_i,
  input  logic [DATA_W-1:0] ram_rdat_i,
  input  logic              csr_ack_i,
  input  logic [DATA_W-1:0] csr_rdat_i,
  input  logic              spi_ack_i,
  input  logic [DATA_W-1:0] spi_rdat_i
);

  logic                stb;
  logic [ADR_W-1:0]    adr;
  logic [REGION_W-1:0] region;
  logic                ram_hit;
  logic                csr_hit;
  logic                spi_hit;
  logic                unm_hit;
  logic                unm_ack_q;
  logic                ack;
  logic [DATA_W-1:0]   rdat;

  // ####################
  // port merge

  // instruction fetch wins whenever it asks
  assign stb    = imem_stb_i | dmem_stb_i;
  assign adr    = imem_stb_i ? imem_adr_i : dmem_adr_i;
  assign we_o   = dmem_we_i & ~imem_stb_i;
  assign be_o   = imem_stb_i ? {BE_W{1'b1}} : dmem_be_i;
  assign wadr_o = adr[RAM_AW+1:2];
  assign wdat_o = dmem_wdat_i;

  // ####################
  // decode

  assign region  = adr[REGION_MSB:REGION_LSB];
  assign ram_hit = (region == REGION_RAM);
  assign csr_hit = (region == REGION_CSR);
  // only the data register answers in the spi region
  assign spi_hit = (region == REGION_SPI) && (wadr_o == SPI_DATA);
  assign unm_hit = ~(ram_hit | csr_hit | spi_hit);

  assign ram_stb_o = stb & ram_hit;
  assign csr_stb_o = stb & csr_hit;
  assign spi_stb_o = stb & spi_hit;

  // unmapped accesses are answered here, writes dropped
  always_ff @(posedge clk_i or negedge rst_in) begin
    if (!rst_in) begin
      unm_ack_q <= 1'b0;
    end else begin
      unm_ack_q <= stb & unm_hit & ~unm_ack_q;
    end
  end

  // ####################
  // response

  always_comb begin
    ack  = unm_ack_q;
    rdat = '0;
    if (ram_hit) begin
      ack  = ram_ack_i;
      rdat = ram_rdat_i;
    end else if (csr_hit) begin
      ack  = csr_ack_i;
      rdat = csr_rdat_i;
    end else if (spi_hit) begin
      ack  = spi_ack_i;
      rdat = spi_rdat_i;
    end
  end

  // ack only to the port being served
  assign imem_ack_o  = ack & imem_stb_i;
  assign dmem_ack_o  = ack & dmem_stb_i & ~imem_stb_i;
  assign imem_rdat_o = rdat;
  assign dmem_rdat_o = rdat;

endmodule

/* logic/core_reset_delay.sv */
`timescale 1ns/1ps

module core_reset_delay #(
  parameter int DELAY = 16
) (
  input  logic clk_i,
  input  logic rst_in,
  output logic core_rst_no
);

  logic                     rel_q;
  logic [$clog2(DELAY)-1:0] cnt_q;

  // first flop takes the release, then count up to the limit
  always_ff @(posedge clk_i or negedge rst_in) begin
    if (!rst_in) begin
      rel_q       <= 1'b0;
      cnt_q       <= '0;
      core_rst_no <= 1'b0;
    end else begin
      rel_q <= 1'b1;
      if (rel_q) begin
        if (cnt_q != $clog2(DELAY)'(DELAY - 1)) begin
          cnt_q <= cnt_q + 1'b1;
        end else begin
          core_rst_no <= 1'b1;
        end
      end
    end
  end

endmodule

/* logic/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_in,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [RAM_AW-1:0] adr_i,
  input  logic [DATA_W-1:0] wdat_i,
  output logic [DATA_W-1:0] rdat_o,
  output logic              ack_o
);

  logic [DATA_W-1:0] mem [RAM_DEPTH];
  logic              req;

  // new request, not the cycle of its own ack
  assign req = stb_i & ~ack_o;

  // byte lane writes and registered read
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (we_i) begin
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem[adr_i][8*b +: 8] <= wdat_i[8*b +: 8];
          end
        end
      end
      rdat_o <= mem[adr_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_in) begin
    if (!rst_in) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req;
    end
  end

endmodule

/* logic/csr_regs.sv */
`timescale 1ns/1ps

module csr_regs import soc_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_in,
  input  logic               stb_i,
  input  logic               we_i,
  input  logic [RAM_AW-1:0]  adr_i,
  input  logic [DATA_W-1:0]  wdat_i,
  output logic [DATA_W-1:0]  rdat_o,
  output logic               ack_o,
  input  logic [GPIO_W-1:0]  gpi_i,
  output logic [GPIO_W-1:0]  gpo_o,
  output logic [GPIO_W-1:0]  gpeo_o,
  output logic [PRESC_W-1:0] spi_presc_o,
  output logic               spi_cpol_o,
  output logic [1:0]         spi_size_o,
  input  logic               spi_rdy_i
);

  logic req;

  assign req = stb_i & ~ack_o;

  // writable registers, gpi and status are read only
  always_ff @(posedge clk_i or negedge rst_in) begin
    if (!rst_in) begin
      ack_o       <= 1'b0;
      gpo_o       <= '0;
      gpeo_o      <= '0;
      spi_presc_o <= '0;
      spi_cpol_o  <= 1'b0;
      spi_size_o  <= SPI_SIZE_8;
    end else begin
      ack_o <= req;
      if (req && we_i) begin
        case (adr_i)
          CSR_GPO:  gpo_o  <= wdat_i[GPIO_W-1:0];
          CSR_GPOE: gpeo_o <= wdat_i[GPIO_W-1:0];
          CSR_SPI_CONF: begin
            spi_presc_o <= wdat_i[PRESC_W-1:0];
            spi_cpol_o  <= wdat_i[CONF_CPOL_BIT];
            spi_size_o  <= wdat_i[CONF_SIZE_LSB +: 2];
          end
          default: ;
        endcase
      end
    end
  end

  // read mux, captured with the request
  always_ff @(posedge clk_i) begin
    if (req) begin
      rdat_o <= '0;
      case (adr_i)
        CSR_GPI:  rdat_o[GPIO_W-1:0] <= gpi_i;
        CSR_GPO:  rdat_o[GPIO_W-1:0] <= gpo_o;
        CSR_GPOE: rdat_o[GPIO_W-1:0] <= gpeo_o;
        CSR_SPI_CONF: begin
          rdat_o[PRESC_W-1:0]         <= spi_presc_o;
          rdat_o[CONF_CPOL_BIT]       <= spi_cpol_o;
          rdat_o[CONF_SIZE_LSB +: 2]  <= spi_size_o;
        end
        CSR_STATUS: rdat_o[0] <= spi_rdy_i;
        default: ;
      endcase
    end
  end

endmodule

/* logic/spi_master.sv */
`timescale 1ns/1ps

module spi_master import soc_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_in,
  // bus side
  input  logic               stb_i,
  input  logic               we_i,
  input  logic [DATA_W-1:0]  wdat_i,
  output logic [DATA_W-1:0]  rdat_o,
  output logic               ack_o,
  // configuration
  input  logic [PRESC_W-1:0] presc_i,
  input  logic               cpol_i,
  input  logic [1:0]         size_i,
  output logic               rdy_o,
  // spi pins
  output logic               spi_cs_o,
  output logic               spi_sck_o,
  output logic               spi_sdo_o,
  input  logic               spi_sdi_i
);

  logic               busy_q;
  logic               lead_q;
  logic               sdi_q;
  logic [PRESC_W-1:0] div_q;
  logic [BCNT_W-1:0]  bits_q;
  logic [BCNT_W-1:0]  nbits;
  logic [DATA_W-1:0]  load;
  logic [DATA_W-1:0]  shift_q;
  logic [DATA_W-1:0]  shift_nxt;
  logic               start;
  logic               half_done;
  logic               last_bit;

  // ####################
  // transfer size

  // word is left aligned so the msb leaves first
  always_comb begin
    case (size_i)
      SPI_SIZE_8: begin
        nbits = BCNT_W'(8);
        load  = {wdat_i[7:0], {(DATA_W-8){1'b0}}};
      end
      SPI_SIZE_16: begin
        nbits = BCNT_W'(16);
        load  = {wdat_i[15:0], {(DATA_W-16){1'b0}}};
      end
      default: begin
        nbits = BCNT_W'(DATA_W);
        load  = wdat_i;
      end
    endcase
  end

  // ####################
  // handshake

  // writes wait while a transfer runs, reads never do
  assign start     = stb_i & we_i & ~ack_o & ~busy_q;
  assign half_done = busy_q & (div_q == presc_i);
  assign last_bit  = (bits_q == BCNT_W'(1));
  assign shift_nxt = {shift_q[DATA_W-2:0], sdi_q};

  always_ff @(posedge clk_i or negedge rst_in) begin
    if (!rst_in) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i & ~ack_o & (~we_i | ~busy_q);
    end
  end

  // ####################
  // sck sequencing

  // lead_q high between leading and trailing edge
  always_ff @(posedge clk_i or negedge rst_in) begin
    if (!rst_in) begin
      busy_q <= 1'b0;
      lead_q <= 1'b0;
      div_q  <= '0;
      bits_q <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      lead_q <= 1'b0;
      div_q  <= '0;
      bits_q <= nbits;
    end else if (half_done) begin
      div_q  <= '0;
      lead_q <= ~lead_q;
      if (lead_q) begin
        bits_q <= bits_q - 1'b1;
        if (last_bit) begin
          busy_q <= 1'b0;
        end
      end
    end else if (busy_q) begin
      div_q <= div_q + 1'b1;
    end
  end

  // sample on leading edge, shift on trailing edge
  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q <= load;
    end else if (half_done) begin
      if (!lead_q) begin
        sdi_q <= spi_sdi_i;
      end else begin
        shift_q <= shift_nxt;
      end
    end
  end

  // received word, upper bits already zero after the last shift
  always_ff @(posedge clk_i or negedge rst_in) begin
    if (!rst_in) begin
      rdat_o <= '0;
    end else if (half_done && lead_q && last_bit) begin
      rdat_o <= shift_nxt;
    end
  end

  assign rdy_o     = ~busy_q;
  assign spi_cs_o  = ~busy_q;
  assign spi_sck_o = cpol_i ^ lead_q;
  assign spi_sdo_o = shift_q[DATA_W-1];

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_in,
  // instruction port
  input  logic              imem_stb_i,
  input  logic [ADR_W-1:0]  imem_adr_i,
  output logic [DATA_W-1:0] imem_rdat_o,
  output logic              imem_ack_o,
  // data port
  input  logic              dmem_stb_i,
  input  logic              dmem_we_i,
  input  logic [BE_W-1:0]   dmem_be_i,
  input  logic [ADR_W-1:0]  dmem_adr_i,
  input  logic [DATA_W-1:0] dmem_wdat_i,
  output logic [DATA_W-1:0] dmem_rdat_o,
  output logic              dmem_ack_o,
  // gpio
  input  logic [GPIO_W-1:0] gpi_i,
  output logic [GPIO_W-1:0] gpo_o,
  output logic [GPIO_W-1:0] gpeo_o,
  // spi
  output logic              spi_cs_o,
  output logic              spi_sck_o,
  output logic              spi_sdo_o,
  input  logic              spi_sdi_i,
  // held reset for the core
  output logic              core_rst_no
);

  // shared slave side
  logic              bus_we;
  logic [BE_W-1:0]   bus_be;
  logic [RAM_AW-1:0] bus_wadr;
  logic [DATA_W-1:0] bus_wdat;

  logic              ram_stb;
  logic              ram_ack;
  logic [DATA_W-1:0] ram_rdat;
  logic              csr_stb;
  logic              csr_ack;
  logic [DATA_W-1:0] csr_rdat;
  logic              spi_stb;
  logic              spi_ack;
  logic [DATA_W-1:0] spi_rdat;

  // spi configuration from the csr block
  logic [PRESC_W-1:0] spi_presc;
  logic               spi_cpol;
  logic [1:0]         spi_size;
  logic               spi_rdy;

  // ####################
  // interconnect

  bus_ctrl i_bus_ctrl (
    .clk_i       ( clk_i       ),
    .rst_in      ( rst_in      ),
    .imem_stb_i  ( imem_stb_i  ),
    .imem_adr_i  ( imem_adr_i  ),
    .imem_rdat_o ( imem_rdat_o ),
    .imem_ack_o  ( imem_ack_o  ),
    .dmem_stb_i  ( dmem_stb_i  ),
    .dmem_we_i   ( dmem_we_i   ),
    .dmem_be_i   ( dmem_be_i   ),
    .dmem_adr_i  ( dmem_adr_i  ),
    .dmem_wdat_i ( dmem_wdat_i ),
    .dmem_rdat_o ( dmem_rdat_o ),
    .dmem_ack_o  ( dmem_ack_o  ),
    .ram_stb_o   ( ram_stb     ),
    .csr_stb_o   ( csr_stb     ),
    .spi_stb_o   ( spi_stb     ),
    .we_o        ( bus_we      ),
    .be_o        ( bus_be      ),
    .wadr_o      ( bus_wadr    ),
    .wdat_o      ( bus_wdat    ),
    .ram_ack_i   ( ram_ack     ),
    .ram_rdat_i  ( ram_rdat    ),
    .csr_ack_i   ( csr_ack     ),
    .csr_rdat_i  ( csr_rdat    ),
    .spi_ack_i   ( spi_ack     ),
    .spi_rdat_i  ( spi_rdat    )
  );

  core_reset_delay #(
    .DELAY ( RST_DELAY )
  ) i_core_reset_delay (
    .clk_i       ( clk_i       ),
    .rst_in      ( rst_in      ),
    .core_rst_no ( core_rst_no )
  );

  // ####################
  // slaves

  wb_ram i_wb_ram (
    .clk_i  ( clk_i    ),
    .rst_in ( rst_in   ),
    .stb_i  ( ram_stb  ),
    .we_i   ( bus_we   ),
    .be_i   ( bus_be   ),
    .adr_i  ( bus_wadr ),
    .wdat_i ( bus_wdat ),
    .rdat_o ( ram_rdat ),
    .ack_o  ( ram_ack  )
  );

  csr_regs i_csr_regs (
    .clk_i       ( clk_i     ),
    .rst_in      ( rst_in    ),
    .stb_i       ( csr_stb   ),
    .we_i        ( bus_we    ),
    .adr_i       ( bus_wadr  ),
    .wdat_i      ( bus_wdat  ),
    .rdat_o      ( csr_rdat  ),
    .ack_o       ( csr_ack   ),
    .gpi_i       ( gpi_i     ),
    .gpo_o       ( gpo_o     ),
    .gpeo_o      ( gpeo_o    ),
    .spi_presc_o ( spi_presc ),
    .spi_cpol_o  ( spi_cpol  ),
    .spi_size_o  ( spi_size  ),
    .spi_rdy_i   ( spi_rdy   )
  );

  spi_master i_spi_master (
    .clk_i     ( clk_i     ),
    .rst_in    ( rst_in    ),
    .stb_i     ( spi_stb   ),
    .we_i      ( bus_we    ),
    .wdat_i    ( bus_wdat  ),
    .rdat_o    ( spi_rdat  ),
    .ack_o     ( spi_ack   ),
    .presc_i   ( spi_presc ),
    .cpol_i    ( spi_cpol  ),
    .size_i    ( spi_size  ),
    .rdy_o     ( spi_rdy   ),
    .spi_cs_o  ( spi_cs_o  ),
    .spi_sck_o ( spi_sck_o ),
    .spi_sdo_o ( spi_sdo_o ),
    .spi_sdi_i ( spi_sdi_i )
  );

endmodule

/* test/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // reset held over the first two rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* test/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;

  localparam logic [31:0] ADR_STATUS = 32'h2000_0010;
  localparam logic [31:0] ADR_CONF   = 32'h2000_000c;
  localparam logic [31:0] ADR_GPO    = 32'h2000_0004;
  localparam logic [31:0] ADR_GPOE   = 32'h2000_0008;
  localparam logic [7:0]  LFSR_TAPS  = 8'hb8;
  localparam int          CASE_CYCLES = 2 * 32 * 16 + 20;

  logic        clk;
  logic        rst_n;
  logic        imem_stb;
  logic [31:0] imem_adr;
  logic [31:0] imem_rdat;
  logic        imem_ack;
  logic        dmem_stb;
  logic        dmem_we;
  logic [3:0]  dmem_be;
  logic [31:0] dmem_adr;
  logic [31:0] dmem_wdat;
  logic [31:0] dmem_rdat;
  logic        dmem_ack;
  logic [7:0]  gpi;
  logic [7:0]  gpo;
  logic [7:0]  gpeo;
  logic        spi_cs;
  logic        spi_sck;
  logic        spi_sdo;
  logic        spi_sdi;
  logic        core_rst_n;

  // case table
  string       c_name[$];
  string       c_port[$];
  string       c_op[$];
  logic [31:0] c_adr[$];
  logic [31:0] c_be[$];
  logic [31:0] c_wdat[$];
  logic [31:0] c_exp[$];

  string       cur_name;
  int          errs;
  int          pass_n;
  int          fail_n;
  int          cycles;
  int          limit = 100;
  logic [7:0]  lfsr_q = 8'd30;
  logic [31:0] conf_q;
  int          sck_total;
  int          cs_total;
  logic        sck_prev;

  clk_gen u_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  soc_top u_dut (
    .clk_i       ( clk        ),
    .rst_in      ( rst_n      ),
    .imem_stb_i  ( imem_stb   ),
    .imem_adr_i  ( imem_adr   ),
    .imem_rdat_o ( imem_rdat  ),
    .imem_ack_o  ( imem_ack   ),
    .dmem_stb_i  ( dmem_stb   ),
    .dmem_we_i   ( dmem_we    ),
    .dmem_be_i   ( dmem_be    ),
    .dmem_adr_i  ( dmem_adr   ),
    .dmem_wdat_i ( dmem_wdat  ),
    .dmem_rdat_o ( dmem_rdat  ),
    .dmem_ack_o  ( dmem_ack   ),
    .gpi_i       ( gpi        ),
    .gpo_o       ( gpo        ),
    .gpeo_o      ( gpeo       ),
    .spi_cs_o    ( spi_cs     ),
    .spi_sck_o   ( spi_sck    ),
    .spi_sdo_o   ( spi_sdo    ),
    .spi_sdi_i   ( spi_sdi    ),
    .core_rst_no ( core_rst_n )
  );

  // loopback
  assign spi_sdi = spi_sdo;

  // ####################
  // monitors

  always @(negedge clk) begin
    if (spi_sck !== sck_prev) sck_total <= sck_total + 1;
    if (!spi_cs) cs_total <= cs_total + 1;
    sck_prev <= spi_sck;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // ####################
  // helpers

  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic next_gpi(output logic [7:0] v);
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v[i]   = lfsr_q[0];
    end
  endtask

  // bit count from the size field of spi_conf
  function automatic int size_bits(input logic [31:0] conf);
    case (conf[6:5])
      2'd0:    return 8;
      2'd1:    return 16;
      default: return 32;
    endcase
  endfunction

  task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("mismatch %s: expected %08h, actual %08h", cur_name, exp, act);
      errs++;
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       nm;
    string       pt;
    string       op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    logic [31:0] e;
    fd = $fopen("test/soc_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/soc_cases.txt");
      fail_n++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %s %s %h %h %h %h", nm, pt, op, a, b, w, e);
          if (n == 7) begin
            c_name.push_back(nm);
            c_port.push_back(pt);
            c_op.push_back(op);
            c_adr.push_back(a);
            c_be.push_back(b);
            c_wdat.push_back(w);
            c_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one request, called and returning just after a falling edge
  task automatic bus_access(input bit instr, input bit we, input logic [3:0] be,
                            input logic [31:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    if (instr) begin
      imem_stb = 1'b1;
      imem_adr = adr;
    end else begin
      dmem_stb  = 1'b1;
      dmem_we   = we;
      dmem_be   = be;
      dmem_adr  = adr;
      dmem_wdat = wdat;
    end
    @(negedge clk);
    while (!(instr ? imem_ack : dmem_ack)) @(negedge clk);
    rdat     = instr ? imem_rdat : dmem_rdat;
    imem_stb = 1'b0;
    dmem_stb = 1'b0;
    dmem_we  = 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_spi_ready();
    logic [31:0] st;
    st = '0;
    while (st[0] !== 1'b1) bus_access(1'b0, 1'b0, 4'hf, ADR_STATUS, '0, st);
  endtask

  task automatic report_test(input string nm, input int e0);
    if (errs == e0) begin
      $display("PASS %s", nm);
      pass_n++;
    end else begin
      $display("FAIL %s", nm);
      fail_n++;
    end
  endtask

  // ####################
  // test sequences

  task automatic check_reset();
    int e0;
    e0 = errs;
    cur_name = "reset";
    @(negedge clk);
    check_value(0, 32'(gpo));
    check_value(0, 32'(gpeo));
    check_value(0, {30'd0, imem_ack, dmem_ack});
    check_value(1, 32'(spi_cs));
    wait (rst_n);
    for (int i = 1; i <= 16; i++) begin
      @(posedge clk);
      @(negedge clk);
      assert (core_rst_n === 1'b0) else begin
        $display("core reset released early, after rising edge %0d", i);
        errs++;
      end
    end
    @(posedge clk);
    @(negedge clk);
    assert (core_rst_n === 1'b1) else begin
      $display("core reset still held after the 17th rising edge");
      errs++;
    end
    report_test("reset", e0);
  endtask

  task automatic run_spi(input logic [31:0] adr, input logic [31:0] wdat,
                         input logic [31:0] exp);
    int          s0;
    int          c0;
    int          n;
    logic [31:0] rd;
    n  = size_bits(conf_q);
    s0 = sck_total;
    c0 = cs_total;
    bus_access(1'b0, 1'b1, 4'hf, adr, wdat, rd);
    wait_spi_ready();
    bus_access(1'b0, 1'b0, 4'hf, adr, '0, rd);
    check_value(exp, rd);
    check_value(32'(2 * n), 32'(sck_total - s0));
    check_value(32'(2 * n * (conf_q[3:0] + 1)), 32'(cs_total - c0));
    assert (spi_cs === 1'b1) else begin
      $display("chip select still low after the transfer in %s", cur_name);
      errs++;
    end
  endtask

  task automatic run_backpressure(input logic [31:0] adr, input logic [31:0] wdat,
                                  input logic [31:0] exp);
    int          s0;
    int          n;
    bit          seen_idle;
    logic [31:0] rd;
    n  = size_bits(conf_q);
    s0 = sck_total;
    bus_access(1'b0, 1'b1, 4'hf, adr, wdat, rd);
    seen_idle = 1'b0;
    dmem_stb  = 1'b1;
    dmem_we   = 1'b1;
    dmem_be   = 4'hf;
    dmem_adr  = adr;
    dmem_wdat = ~wdat;
    @(negedge clk);
    while (!dmem_ack) begin
      if (spi_cs) seen_idle = 1'b1;
      @(negedge clk);
    end
    check_value(32'(2 * n), 32'(sck_total - s0));
    dmem_stb = 1'b0;
    dmem_we  = 1'b0;
    @(negedge clk);
    assert (seen_idle) else begin
      $display("second write acked while the first transfer was running");
      errs++;
    end
    wait_spi_ready();
    bus_access(1'b0, 1'b0, 4'hf, adr, '0, rd);
    check_value(exp, rd);
  endtask

  task automatic run_arbitration(input logic [31:0] adr, input logic [31:0] exp_d,
                                 input logic [31:0] exp_i);
    bit          got_i;
    bit          done;
    logic [31:0] ri;
    logic [31:0] rd;
    got_i    = 1'b0;
    done     = 1'b0;
    ri       = '0;
    rd       = '0;
    imem_stb = 1'b1;
    imem_adr = adr;
    dmem_stb = 1'b1;
    dmem_we  = 1'b0;
    dmem_be  = 4'hf;
    dmem_adr = adr + 32'd4;
    while (!done) begin
      @(negedge clk);
      if (imem_ack) begin
        got_i    = 1'b1;
        ri       = imem_rdat;
        imem_stb = 1'b0;
      end else if (dmem_ack) begin
        assert (got_i) else begin
          $display("data port was acked before the instruction port");
          errs++;
        end
        rd   = dmem_rdat;
        done = 1'b1;
      end
    end
    dmem_stb = 1'b0;
    @(negedge clk);
    check_value(exp_i, ri);
    check_value(exp_d, rd);
  endtask

  // ####################
  // main

  initial begin
    logic [31:0] rd;
    logic [7:0]  g;
    int          e0;
    imem_stb  = 1'b0;
    imem_adr  = '0;
    dmem_stb  = 1'b0;
    dmem_we   = 1'b0;
    dmem_be   = '0;
    dmem_adr  = '0;
    dmem_wdat = '0;
    gpi       = '0;
    conf_q    = '0;
    errs      = 0;
    pass_n    = 0;
    fail_n    = 0;
    cycles    = 0;
    sck_total = 0;
    cs_total  = 0;
    sck_prev  = 1'b0;
    load_cases();
    limit = c_name.size() * CASE_CYCLES + 100;

    check_reset();

    foreach (c_name[k]) begin
      e0 = errs;
      cur_name = c_name[k];
      case (c_op[k])
        "w": begin
          bus_access(1'b0, 1'b1, c_be[k][3:0], c_adr[k], c_wdat[k], rd);
          if (c_adr[k] == ADR_CONF) conf_q = c_wdat[k];
          if (c_adr[k] == ADR_GPO) check_value(c_wdat[k][7:0], 32'(gpo));
          if (c_adr[k] == ADR_GPOE) check_value(c_wdat[k][7:0], 32'(gpeo));
        end
        "r": begin
          bus_access(c_port[k] == "i", 1'b0, c_be[k][3:0], c_adr[k], '0, rd);
          check_value(c_exp[k], rd);
        end
        "gpi": begin
          next_gpi(g);
          gpi = g;
          bus_access(1'b0, 1'b0, 4'hf, c_adr[k], '0, rd);
          check_value(32'(g), rd);
        end
        "spi":  run_spi(c_adr[k], c_wdat[k], c_exp[k]);
        "bp":   run_backpressure(c_adr[k], c_wdat[k], c_exp[k]);
        "arb":  run_arbitration(c_adr[k], c_wdat[k], c_exp[k]);
        default: begin
          $display("unknown operation %s in case %s", c_op[k], c_name[k]);
          errs++;
        end
      endcase
      report_test(c_name[k], e0);
    end

    $display("tests passed %0d, failed %0d", pass_n, fail_n);
    if (fail_n == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* test/soc_cases.txt */
# name port op addr be wdat expect (hex)
# op: w write, r read, gpi, spi loopback, bp write during transfer, arb (wdat holds dmem value)
ram_full   d w   00000010 f 11223344 00000000
ram_part   d w   00000010 3 aabbccdd 00000000
ram_rd_d   d r   00000010 f 00000000 1122ccdd
ram_rd_i   i r   00000010 f 00000000 1122ccdd
ram_next   d w   00000014 f 55667788 00000000
arb_both   i arb 00000010 f 55667788 1122ccdd
gpo_wr     d w   20000004 f 000000a5 00000000
gpoe_wr    d w   20000008 f 0000003c 00000000
gpo_rd     d r   20000004 f 00000000 000000a5
gpoe_rd    d r   20000008 f 00000000 0000003c
gpi_rd     d gpi 20000000 f 00000000 00000000
conf_8     d w   2000000c f 00000001 00000000
spi_8      d spi 30000000 f 0000015a 0000005a
conf_16    d w   2000000c f 00000030 00000000
spi_16     d spi 30000000 f 1234beef 0000beef
conf_32    d w   2000000c f 00000052 00000000
spi_32     d spi 30000000 f cafe1234 cafe1234
conf_32c0  d w   2000000c f 00000040 00000000
spi_32c0   d spi 30000000 f a5a50ff0 a5a50ff0
spi_bp     d bp  30000000 f 12345678 edcba987
unmapped   d r   50000000 f 00000000 00000000
conf_rd    d r   2000000c f 00000000 00000040

/* src.f */
logic/soc_pkg.sv
logic/bus_ctrl.sv
logic/core_reset_delay.sv
logic/wb_ram.sv
logic/csr_regs.sv
logic/spi_master.sv
logic/soc_top.sv
test/clk_gen.sv
test/tb_soc.sv

/* run.sh */
#!/bin/sh
# build and run the testbench from the project root
verilator --binary --timing --assert --top-module tb_soc -f src.f -o tb_soc \
  && ./obj_dir/tb_soc | tee /dev/stderr | grep -q "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
